/* src.f */
+incdir+src
src/vga_pkg.sv
src/vga_timing.sv
src/pixel_fetch_fsm.sv
src/delay_ring.sv
src/pixel_unpack.sv
src/vga_write.sv
testbench/vga_write_tb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
verilator --binary --assert --top-module vga_write_tb -f src.f -o vga_sim > build.log 2>&1 \
	&& ./obj_dir/vga_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
exit 0

/* testbench/vga_write_tb.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module vga_write_tb;
	import vga_pkg::*;

	typedef struct packed {
		int h;
		int v;
		bit hs;    // expected pin levels
		bit vs;
		bit bb;
		bit pix;   // rgb from the word rule when set
		bit rst;   // pulse frame_restart after this check
	} check_row_t;

	localparam int NROWS = 28;
	localparam int TIMEOUT_CYCLES = 2 * `VGA_H_TOTAL * `VGA_V_TOTAL + 1000;
	localparam check_row_t ROWS [NROWS] = '{
		'{0, 0, 1, 1, 1, 1, 0}, '{1, 0, 1, 1, 1, 1, 0}, '{2, 0, 1, 1, 1, 1, 0},
		'{3, 0, 1, 1, 1, 1, 0}, '{4, 0, 1, 1, 1, 1, 0}, '{639, 0, 1, 1, 1, 1, 0},
		'{640, 0, 1, 1, 0, 0, 0}, '{655, 0, 1, 1, 0, 0, 0}, '{656, 0, 0, 1, 0, 0, 0},
		'{751, 0, 0, 1, 0, 0, 0}, '{752, 0, 1, 1, 0, 0, 0}, '{0, 1, 1, 1, 1, 1, 0},
		'{317, 240, 1, 1, 1, 1, 0}, '{639, 479, 1, 1, 1, 1, 0}, '{0, 480, 1, 1, 0, 0, 0},
		'{5, 489, 1, 1, 0, 0, 0}, '{0, 490, 1, 0, 0, 0, 0}, '{700, 490, 0, 0, 0, 0, 0},
		'{799, 491, 1, 0, 0, 0, 0}, '{0, 492, 1, 1, 0, 0, 0}, '{799, 524, 1, 1, 0, 0, 0},
		'{2, 0, 1, 1, 1, 1, 0}, '{322, 100, 1, 1, 1, 1, 1},   // second frame then a restart
		'{0, 0, 1, 1, 1, 1, 0}, '{1, 0, 1, 1, 1, 1, 0}, '{6, 0, 1, 1, 1, 1, 0},
		'{640, 0, 1, 1, 0, 0, 0}, '{11, 1, 1, 1, 1, 1, 0}
	};

	logic vclock;
	logic reset;
	logic frame_restart;
	logic mem_req;
	logic [`LOG_ADDR-1:0] mem_addr;
	logic mem_valid;
	mem_word_t mem_word;
	rgb_t rgb;
	logic hsync;
	logic vsync;
	logic blank_b;

	int errors;
	int checks;
	int cycles;
	int since_start;     // cycles since raster (0,0)
	int rh, rv;          // position the raster counter produces
	int ph, pv;          // position on the pins
	bit fresh;
	bit req_s1, req_s2;  // memory latency pipe
	logic [`LOG_ADDR-1:0] addr_s1, addr_s2;
	logic [31:0] lfsr = 32'hce40c679;
	bit spot_at [int];

	vga_write dut (.*);

	function automatic mem_word_t word_at(input int addr);
		mem_word_t w;
		for (int k = 0; k < `PIX_PER_WORD; k++) begin
			w[k] = 8'(4 * addr + k) ^ 8'h5a;
		end
		return w;
	endfunction

	function automatic int expected_rgb(input int h, input int v);
		mem_word_t w;
		pixel_t g;
		w = word_at((v * `VGA_H_VISIBLE + h) / `PIX_PER_WORD);
		g = w[h % `PIX_PER_WORD];
		return int'({g, g, g});   // same grey on all three
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_next_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic int random_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr_next_bit());
		end
		return value;
	endfunction

	task automatic step_position(inout int h, inout int v);
		h = h + 1;
		if (h == `VGA_H_TOTAL) begin
			h = 0;
			v = (v + 1) % `VGA_V_TOTAL;
		end
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		checks++;
		assert (got == expected) else begin
			errors++;
			$display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	initial begin
		vclock = 1'b0;
		forever #5 vclock = ~vclock;
	end

	//////////////////////////////////////////////////////////////////////
	// memory model answering two cycles after the request
	//////////////////////////////////////////////////////////////////////

	initial begin
		mem_valid = 1'b0;
		mem_word = '0;
		forever begin
			@(posedge vclock);
			#1;
			mem_valid = req_s2;
			mem_word = req_s2 ? word_at(int'(addr_s2)) : '0;
		end
	end

	// position counters for the cycle that just started
	always @(posedge vclock) begin
		#2;
		if (reset) begin
			fresh = 1'b1;
		end else begin
			if (fresh) begin
				since_start = 0;
				rh = 0;
				rv = 0;
			end else begin
				since_start++;
				step_position(rh, rv);
			end
			if (since_start == `PIPE_DELAY) begin
				ph = 0;
				pv = 0;
			end else if (since_start > `PIPE_DELAY) begin
				step_position(ph, pv);
			end
			fresh = frame_restart;   // takes effect next cycle
		end
	end

	always @(negedge vclock) begin
		if (reset) begin
			check_value("mem_req", int'(mem_req), 0);
		end else begin
			if (since_start < `PIPE_DELAY) begin
				check_value("hsync", int'(hsync), 1);
				check_value("vsync", int'(vsync), 1);
				check_value("blank_b", int'(blank_b), 0);
				check_value("rgb", int'(rgb), 0);
			end else if (spot_at.exists(pv * `VGA_H_TOTAL + ph)) begin
				check_value("rgb", int'(rgb), expected_rgb(ph, pv));
			end
			check_value("mem_req", int'(mem_req), int'((rh % `PIX_PER_WORD == 0) &&
				(rh < `VGA_H_VISIBLE) && (rv < `VGA_V_VISIBLE)));
			if (mem_req) begin
				check_value("mem_addr", int'(mem_addr), (rv * `VGA_H_VISIBLE + rh) / 4);
			end
		end
		req_s2 = req_s1;
		addr_s2 = addr_s1;
		req_s1 = mem_req;
		addr_s1 = mem_addr;
	end

	always @(posedge vclock) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: test still running after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// table walk
	//////////////////////////////////////////////////////////////////////

	initial begin
		check_row_t r;
		reset = 1'b1;
		frame_restart = 1'b0;
		for (int i = 0; i < 64; i++) begin
			spot_at[(random_bits(9) % `VGA_V_VISIBLE) * `VGA_H_TOTAL +
				random_bits(10) % `VGA_H_VISIBLE] = 1'b1;
		end
		repeat (5) @(posedge vclock);
		#1 reset = 1'b0;
		for (int i = 0; i < NROWS; i++) begin
			r = ROWS[i];
			do @(negedge vclock);
			while (!(since_start >= `PIPE_DELAY && ph == r.h && pv == r.v));
			check_value("hsync", int'(hsync), int'(r.hs));
			check_value("vsync", int'(vsync), int'(r.vs));
			check_value("blank_b", int'(blank_b), int'(r.bb));
			check_value("rgb", int'(rgb), r.pix ? expected_rgb(r.h, r.v) : 0);
			if (r.rst) begin
				@(posedge vclock);
				#1 frame_restart = 1'b1;
				@(posedge vclock);
				#1 frame_restart = 1'b0;
			end
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* src/vga_write.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module vga_write (
	input  logic                 vclock,
	input  logic                 reset,
	input  logic                 frame_restart,
	output logic                 mem_req,
	output logic [`LOG_ADDR-1:0] mem_addr,
	input  logic                 mem_valid,
	input  vga_pkg::mem_word_t   mem_word,
	output vga_pkg::rgb_t        rgb,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 blank_b
);
	import vga_pkg::*;

	localparam int START_W = $clog2(`PIPE_DELAY + 1);

	sync_t raster;
	sync_t shown;   // raster, PIPE_DELAY cycles late
	mem_word_t fetched_word;
	logic word_load;
	rgb_t unpacked_rgb;
	logic [START_W-1:0] startup_cnt;
	logic pins_live;

	vga_timing u_timing (
		.vclock(vclock), .reset(reset), .frame_restart(frame_restart), .raster(raster)
	);

	pixel_fetch_fsm u_fetch (
		.vclock(vclock), .reset(reset), .frame_restart(frame_restart),
		.raster(raster), .mem_req(mem_req), .mem_addr(mem_addr),
		.mem_valid(mem_valid), .mem_word(mem_word),
		.word_load(word_load), .fetched_word(fetched_word)
	);

	delay_ring #(.payload_t(sync_t)) u_ring (
		.vclock(vclock), .reset(reset), .din(raster), .dout(shown)
	);

	pixel_unpack u_unpack (
		.vclock(vclock), .reset(reset), .word_load(word_load),
		.fetched_word(fetched_word), .shown(shown), .rgb(unpacked_rgb)
	);

	////////////////////////////////////////////////////////////////////
	// start-up gating, pins idle until the ring holds the new raster
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge vclock) begin
		if (reset || frame_restart) begin
			startup_cnt <= '0;
		end else if (!pins_live) begin
			startup_cnt <= startup_cnt + 1'b1;
		end
	end

	assign pins_live = (startup_cnt == `PIPE_DELAY);

	assign hsync   = pins_live ? shown.hsync : 1'b1;
	assign vsync   = pins_live ? shown.vsync : 1'b1;
	assign blank_b = pins_live ? ~shown.blank : 1'b0;
	assign rgb     = pins_live ? unpacked_rgb : '0;

	// first live pixel is the top left corner
	a_first_pixel: assert property (
		@(posedge vclock) disable iff (reset)
		$rose(pins_live) |-> (shown.hcount == 0) && (shown.vcount == 0)
	);

endmodule

/* src/pixel_unpack.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module pixel_unpack (
	input  logic               vclock,
	input  logic               reset,
	input  logic               word_load,
	input  vga_pkg::mem_word_t fetched_word,
	input  vga_pkg::sync_t     shown,
	output vga_pkg::rgb_t      rgb
);
	import vga_pkg::*;

	localparam int PIX_IDX_W = $clog2(`PIX_PER_WORD);

	mem_word_t slots [2];
	logic slot_sel;   // slot of the group on the pins
	logic [PIX_IDX_W-1:0] pix_idx;
	pixel_t grey;

	////////////////////////////////////////////////////////////////////
	// ping-pong word store
	////////////////////////////////////////////////////////////////////

	// a load lands as the last pixel of the older group leaves, so the
	// flip coincides with shown hcount mod 4 returning to 0
	always_ff @(posedge vclock) begin
		if (reset) begin
			slot_sel <= 1'b0;
		end else if (word_load) begin
			slot_sel <= ~slot_sel;
		end
	end

	always_ff @(posedge vclock) begin
		if (word_load) begin
			slots[slot_sel] <= fetched_word;   // read out this cycle, replaced at the edge
		end
	end

	assign pix_idx = shown.hcount[PIX_IDX_W-1:0];
	assign grey    = slots[slot_sel][pix_idx];

	always_comb begin
		if (shown.blank) begin
			rgb = '0;
		end else begin
			rgb = '{red: grey, green: grey, blue: grey};   // greyscale
		end
	end

	// loads at least a group apart, so no word is replaced while
	// any of its pixels is still waiting for the pins
	a_load_spacing: assert property (
		@(posedge vclock) disable iff (reset)
		word_load |=> !word_load [*(`PIX_PER_WORD - 1)]
	);

endmodule

/* src/delay_ring.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module delay_ring #(
	parameter type payload_t = logic
) (
	input  logic     vclock,
	input  logic     reset,
	input  payload_t din,
	output payload_t dout
);

	localparam int IDX_W = (`PIPE_DELAY > 1) ? $clog2(`PIPE_DELAY) : 1;

	payload_t ring [`PIPE_DELAY];
	logic [IDX_W-1:0] widx;

	////////////////////////////////////////////////////////////////////
	// write pointer walks the ring once every PIPE_DELAY cycles
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge vclock) begin
		if (reset) begin
			widx <= '0;
		end else if (widx == `PIPE_DELAY - 1) begin
			widx <= '0;
		end else begin
			widx <= widx + 1'b1;
		end
	end

	always_ff @(posedge vclock) begin
		ring[widx] <= din;
	end

	// the slot about to be overwritten holds the oldest entry,
	// written exactly PIPE_DELAY edges ago
	assign dout = ring[widx];

endmodule

/* src/pixel_fetch_fsm.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module pixel_fetch_fsm (
	input  logic                 vclock,
	input  logic                 reset,
	input  logic                 frame_restart,
	input  vga_pkg::sync_t       raster,
	output logic                 mem_req,
	output logic [`LOG_ADDR-1:0] mem_addr,
	input  logic                 mem_valid,
	input  vga_pkg::mem_word_t   mem_word,
	output logic                 word_load,
	output vga_pkg::mem_word_t   fetched_word
);
	import vga_pkg::*;

	typedef enum logic [1:0] {
		REQUESTING,
		STANDING_BY,
		READING,
		OUT_OF_BOUNDS
	} fetch_state_t;

	fetch_state_t state;
	logic [`LOG_ADDR-1:0] word_addr;
	logic group_start;   // raster sits on the first pixel of a group
	logic frame_last;    // last raster position of the frame

	assign group_start = (raster.hcount % `PIX_PER_WORD) == 0;
	assign frame_last  = (raster.hcount == `VGA_H_TOTAL - 1) &&
		(raster.vcount == `VGA_V_TOTAL - 1);

	// blank marks columns and lines outside the picture
	assign mem_req  = !reset && (state == REQUESTING) && group_start && !raster.blank;
	assign mem_addr = word_addr;

	////////////////////////////////////////////////////////////////////
	// fetch sequence of one group every four cycles
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge vclock) begin
		if (reset || frame_restart) begin
			state     <= REQUESTING;
			word_load <= 1'b0;
			word_addr <= '0;
		end else begin
			word_load <= (state == READING);   // lands 3 cycles after the group start
			case (state)
				REQUESTING: begin
					if (group_start) begin
						state <= raster.blank ? OUT_OF_BOUNDS : STANDING_BY;
					end
				end
				STANDING_BY:   state <= READING;   // memory latency
				OUT_OF_BOUNDS: state <= READING;   // same pace without a request
				default:       state <= REQUESTING;
			endcase
			if (frame_last) begin
				word_addr <= '0;
			end else if (mem_req) begin
				word_addr <= word_addr + 1'b1;
			end
		end
	end

	// no answer means the group was not requested and stays black
	always_ff @(posedge vclock) begin
		if (state == READING) begin
			fetched_word <= mem_valid ? mem_word : '0;
		end
	end

	////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////

	// fixed two cycle memory latency
	a_valid_latency: assert property (
		@(posedge vclock) disable iff (reset)
		mem_valid |-> $past(mem_req, 2)
	);

	// requests only for pixels inside the picture
	a_req_visible: assert property (
		@(posedge vclock) disable iff (reset)
		mem_req |-> (raster.hcount < `VGA_H_VISIBLE) && (raster.vcount < `VGA_V_VISIBLE)
	);

endmodule

/* src/vga_timing.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module vga_timing (
	input  logic           vclock,
	input  logic           reset,
	input  logic           frame_restart,
	output vga_pkg::sync_t raster
);
	import vga_pkg::*;

	// top left corner, syncs idle
	localparam sync_t RASTER_HOME = '{
		hcount: '0,
		vcount: '0,
		hsync:  1'b1,
		vsync:  1'b1,
		blank:  1'b0
	};

	logic [`LOG_HCOUNT-1:0] next_h;
	logic [`LOG_VCOUNT-1:0] next_v;
	logic line_end;
	logic frame_end;

	assign line_end  = (raster.hcount == `VGA_H_TOTAL - 1);
	assign frame_end = (raster.vcount == `VGA_V_TOTAL - 1);

	////////////////////////////////////////////////////////////////////
	// next position
	////////////////////////////////////////////////////////////////////

	always_comb begin
		next_h = line_end ? '0 : raster.hcount + 1'b1;
		next_v = raster.vcount;
		if (line_end) begin
			next_v = frame_end ? '0 : raster.vcount + 1'b1;  // one line per wrap
		end
	end

	// sync and blank are decoded from the next counts and registered
	// together with them, so all fields describe the same position
	always_ff @(posedge vclock) begin
		if (reset || frame_restart) begin
			raster <= RASTER_HOME;
		end else begin
			raster.hcount <= next_h;
			raster.vcount <= next_v;
			raster.hsync  <= !((next_h >= `VGA_H_SYNC_ON) && (next_h < `VGA_H_SYNC_OFF));
			raster.vsync  <= !((next_v >= `VGA_V_SYNC_ON) && (next_v < `VGA_V_SYNC_OFF));
			raster.blank  <= (next_h >= `VGA_H_VISIBLE) || (next_v >= `VGA_V_VISIBLE);
		end
	end

	////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////

	// column never runs past the raster width
	a_hcount_range: assert property (
		@(posedge vclock) disable iff (reset)
		raster.hcount < `VGA_H_TOTAL
	);

endmodule

/* src/vga_pkg.sv */
`include "vga_defines.svh"

package vga_pkg;

	////////////////////////////////////////////////////////////////////
	// raster position and sync bundle
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`LOG_HCOUNT-1:0] hcount;
		logic [`LOG_VCOUNT-1:0] vcount;
		logic                   hsync;   // active low
		logic                   vsync;   // active low
		logic                   blank;   // outside the 640x480 area
	} sync_t;

	////////////////////////////////////////////////////////////////////
	// pixel data
	////////////////////////////////////////////////////////////////////

	typedef logic [7:0] pixel_t;   // grey level

	// element k is byte k, element 0 is the leftmost pixel of the group
	typedef pixel_t [`PIX_PER_WORD-1:0] mem_word_t;

	typedef struct packed {
		pixel_t red;
		pixel_t green;
		pixel_t blue;
	} rgb_t;

endpackage

/* src/vga_defines.svh */
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

////////////////////////////////////////////////////////////////////////
// raster timing, 640x480 at 60 Hz on an 800x525 raster
////////////////////////////////////////////////////////////////////////

`define VGA_H_VISIBLE   640   // first blanked column
`define VGA_H_SYNC_ON   656   // end of front porch
`define VGA_H_SYNC_OFF  752   // end of sync pulse
`define VGA_H_TOTAL     800

`define VGA_V_VISIBLE   480   // first blanked line
`define VGA_V_SYNC_ON   490
`define VGA_V_SYNC_OFF  492
`define VGA_V_TOTAL     525

////////////////////////////////////////////////////////////////////////
// widths and pipeline
////////////////////////////////////////////////////////////////////////

`define LOG_HCOUNT      10
`define LOG_VCOUNT      10
`define PIPE_DELAY      8     // raster count to pins, in cycles
`define PIX_PER_WORD    4     // grey pixels per memory word

// 76800 words per frame, so the word address needs 17 bits
`define LOG_ADDR        17

`endif
